// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Instruction and program counter width
    localparam int word_width = 32;

    ////////////////////////////////////////
    // Opcodes and states
    ////////////////////////////////////////

    // Next-address select for the program counter
    typedef enum logic [1:0] {
        PC_HOLD,
        PC_INCR,
        PC_JUMP
    } pc_sel_t;

    // Program loader FSM states
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WRITE,
        LD_ACK
    } load_state_t;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    // One host transfer on the load port
    typedef struct packed {
        logic [word_width-1:0] addr;
        logic [word_width-1:0] data;
    } load_word_t;

    // Write strobe from the loader into the memory
    typedef struct packed {
        logic                  en;
        logic [word_width-1:0] addr;
        logic [word_width-1:0] data;
    } mem_write_t;

    // Read request from the sequencer
    typedef struct packed {
        logic                  advance;
        logic [word_width-1:0] next_pc;
    } fetch_req_t;

    // Stage output towards IF/ID
    typedef struct packed {
        logic [word_width-1:0] instruction;
        logic [word_width-1:0] instruction_address;
        logic                  valid;
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== pc_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_sequencer
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               if_id_write,
    input  logic                               pc_write,
    input  logic                               pc_sel_jump,
    input  logic                               stop_debug,
    input  logic                               load_program,
    input  logic [fetch_pkg::word_width-1:0]   pc_jump,
    output fetch_pkg::fetch_req_t              fetch_req,
    output logic [fetch_pkg::word_width-1:0]   instruction_address,
    output logic                               valid
);

    import fetch_pkg::*;

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    logic                  advance;
    pc_sel_t               pc_sel;
    logic [word_width-1:0] pc;
    logic [word_width-1:0] next_pc;

    // Stage moves only when IF/ID accepts and no debug stop or load session
    assign advance = if_id_write && !stop_debug && !load_program;

    // Jump wins over increment
    always_comb
    begin
        if (pc_sel_jump)
            pc_sel = PC_JUMP;
        else if (pc_write)
            pc_sel = PC_INCR;
        else
            pc_sel = PC_HOLD;
    end

    // Next address mux
    always_comb
    begin
        case (pc_sel)
            PC_JUMP:
                next_pc = pc_jump;
            PC_INCR:
                next_pc = pc + 1'b1;
            default:
                next_pc = pc;
        endcase
    end

    ////////////////////////////////////////
    // Program counter and valid
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (advance)
            pc <= next_pc;
    end

    // Valid drops for a load session, comes back on the first advance after it
    always_ff @(posedge clk)
    begin
        if (rst)
            valid <= 1'b0;
        else if (load_program)
            valid <= 1'b0;
        else if (advance)
            valid <= 1'b1;
    end

    // Address of the following word
    assign instruction_address = pc + 1'b1;

    // Memory reads at next_pc on the same edge the PC loads it
    assign fetch_req = '{advance: advance, next_pc: next_pc};

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Back-pressure holds the PC across the edge
    pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        !advance |=> $stable(pc)
    )
    else
        $error("pc changed without advance");

endmodule

`default_nettype wire

// ==== program_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_loader
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_program,
    input  logic                   load_req,
    input  fetch_pkg::load_word_t  load_word,
    output logic                   load_ack,
    output fetch_pkg::mem_write_t  mem_write
);

    import fetch_pkg::*;

    load_state_t state;
    load_state_t state_next;
    load_word_t  word_q;
    logic        req_start;

    // New request, only honoured inside a load session
    assign req_start = (state == LD_IDLE) && load_req && load_program;

    ////////////////////////////////////////
    // Four-phase FSM
    ////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            LD_IDLE:
                if (req_start)
                    state_next = LD_WRITE;
            LD_WRITE:
                state_next = LD_ACK;
            LD_ACK:
                // Wait for host to drop req
                if (!load_req)
                    state_next = LD_IDLE;
            default:
                state_next = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= LD_IDLE;
        else
            state <= state_next;
    end

    // Host word latched at request start
    always_ff @(posedge clk)
    begin
        if (req_start)
            word_q <= load_word;
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // Ack held until req falls, so one transfer gives one write
    assign load_ack = (state == LD_ACK);

    // Single-cycle write strobe
    assign mem_write = '{
        en:   (state == LD_WRITE),
        addr: word_q.addr,
        data: word_q.data
    };

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Ack rises only while the host still holds req
    ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(load_ack) |-> $past(load_req)
    )
    else
        $error("load_ack rose without a pending load_req");

    // One write per transfer
    write_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        mem_write.en |=> !mem_write.en
    )
    else
        $error("mem_write.en held for two cycles");

endmodule

`default_nettype wire

// ==== instruction_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module instruction_memory
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                               clk,
    input  logic                               rst,
    input  fetch_pkg::mem_write_t              mem_write,
    input  fetch_pkg::fetch_req_t              fetch_req,
    output logic [fetch_pkg::word_width-1:0]   instruction
);

    import fetch_pkg::*;

    localparam int depth = 2 ** ADDR_WIDTH;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    logic [word_width-1:0] mem [depth];
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [ADDR_WIDTH-1:0] wr_index;
    logic [ADDR_WIDTH-1:0] rd_index;

    // Only the low address bits index the array
    assign wr_index = mem_write.addr[ADDR_WIDTH-1:0];
    assign rd_index = fetch_req.next_pc[ADDR_WIDTH-1:0];

    // Single port, loader write has the port while it strobes
    assign mem_addr = mem_write.en ? wr_index : rd_index;

    always_ff @(posedge clk)
    begin
        if (mem_write.en)
            mem[mem_addr] <= mem_write.data;
    end

    ////////////////////////////////////////
    // Fetch register
    ////////////////////////////////////////

    // Word at next_pc, captured together with the PC update
    always_ff @(posedge clk)
    begin
        if (rst)
            instruction <= '0;
        else if (fetch_req.advance)
            instruction <= mem[mem_addr];
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Load session and fetch never share the port
    no_write_during_fetch: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_write.en && fetch_req.advance)
    )
    else
        $error("memory write and fetch advance in the same cycle");

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               if_id_write,
    input  logic                               pc_write,
    input  logic                               pc_sel_jump,
    input  logic                               stop_debug,
    input  logic                               load_program,
    input  logic                               load_req,
    input  logic [fetch_pkg::word_width-1:0]   pc_jump,
    input  fetch_pkg::load_word_t              load_word,
    output logic                               load_ack,
    output fetch_pkg::fetch_out_t              fetch_out
);

    import fetch_pkg::*;

    mem_write_t            mem_write;
    fetch_req_t            fetch_req;
    logic [word_width-1:0] instruction;
    logic [word_width-1:0] instruction_address;
    logic                  valid;

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    // PC and next address
    pc_sequencer pc_sequencer_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_id_write         (if_id_write),
        .pc_write            (pc_write),
        .pc_sel_jump         (pc_sel_jump),
        .stop_debug          (stop_debug),
        .load_program        (load_program),
        .pc_jump             (pc_jump),
        .fetch_req           (fetch_req),
        .instruction_address (instruction_address),
        .valid               (valid)
    );

    // Debug host load port
    program_loader program_loader_i (
        .clk          (clk),
        .rst          (rst),
        .load_program (load_program),
        .load_req     (load_req),
        .load_word    (load_word),
        .load_ack     (load_ack),
        .mem_write    (mem_write)
    );

    instruction_memory #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) instruction_memory_i (
        .clk         (clk),
        .rst         (rst),
        .mem_write   (mem_write),
        .fetch_req   (fetch_req),
        .instruction (instruction)
    );

    // Instruction and its address change on the same edge
    assign fetch_out = '{
        instruction:         instruction,
        instruction_address: instruction_address,
        valid:               valid
    };

endmodule

`default_nettype wire

// ==== tb_fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_stage;

    import fetch_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  if_id_write;
    logic                  pc_write;
    logic                  pc_sel_jump;
    logic                  stop_debug;
    logic                  load_program;
    logic                  load_req;
    logic [word_width-1:0] pc_jump;
    load_word_t            load_word;
    logic                  load_ack;
    fetch_out_t            fetch_out;
    // Every word the host has loaded, by low address bits
    logic [word_width-1:0] model [256];
    logic                  advance;
    int                    errors = 0;
    int                    timeouts = 0;

    always #20 clk = ~clk;

    fetch_stage #(.ADDR_WIDTH(8)) fetch_stage_i (.*);

    assign advance = if_id_write && !stop_debug && !load_program;

    task automatic count_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_reset: assert property (@(posedge clk) $fell(rst) |-> !load_ack && !fetch_out.valid
        && fetch_out.instruction_address == 1) else count_error("outputs wrong after reset");
    // Ack two edges after a fresh request
    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(load_req) && load_program |-> ##2 load_ack) else count_error("load_ack late");
    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        !load_req && $past(!load_req) |-> !load_ack) else count_error("load_ack stuck high");
    a_word: assert property (@(posedge clk) disable iff (rst) fetch_out.valid
        |-> fetch_out.instruction === model[fetch_out.instruction_address[7:0] - 8'd1])
        else count_error("instruction does not match loaded word");
    a_incr: assert property (@(posedge clk) disable iff (rst) advance && pc_write && !pc_sel_jump
        |=> fetch_out.instruction_address == $past(fetch_out.instruction_address) + 1)
        else count_error("address did not step by one");
    // Both back-pressure sources freeze the whole output
    a_stall: assert property (@(posedge clk) disable iff (rst) !if_id_write && !load_program
        |=> $stable(fetch_out)) else count_error("fetch_out moved during stall");
    a_stop: assert property (@(posedge clk) disable iff (rst) stop_debug && !load_program
        |=> $stable(fetch_out)) else count_error("fetch_out moved during debug stop");
    a_jump: assert property (@(posedge clk) disable iff (rst) advance && pc_sel_jump
        |=> fetch_out.instruction_address == $past(pc_jump) + 1
        && fetch_out.instruction === model[$past(pc_jump[7:0])])
        else count_error("jump target not fetched");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        advance && !pc_write && !pc_sel_jump && fetch_out.valid
        |=> $stable(fetch_out.instruction) && $stable(fetch_out.instruction_address))
        else count_error("hold changed the fetch");
    a_reload: assert property (@(posedge clk) disable iff (rst) $rose(load_program)
        |=> !fetch_out.valid) else count_error("valid stayed high in load session");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic step(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    // Bounded wait on the ack level
    task automatic wait_ack(input logic level);
        int n = 0;
        while (load_ack !== level && n < 16)
        begin
            step(1);
            n++;
        end
        if (load_ack !== level)
        begin
            timeouts++;
            $display("Timed out waiting for load_ack to go to %0b", level);
        end
    endtask

    // One full four-phase transfer
    task automatic load_one(input logic [word_width-1:0] addr, input logic [word_width-1:0] data);
        model[addr[7:0]] = data;
        load_word = '{addr: addr, data: data};
        load_req = 1'b1;
        wait_ack(1'b1);
        load_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic load_session(input int count);
        load_program = 1'b1;
        step(1);
        for (int i = 0; i < count; i++)
            load_one(i, $urandom());
        load_program = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'h8e1b_9c71));
        {rst, if_id_write, pc_write, pc_sel_jump, stop_debug, load_program, load_req} = 7'h40;
        pc_jump = '0;
        load_word = '0;
        step(8);
        rst = 1'b0;
        load_session(32);
        // Straight-line fetch
        {if_id_write, pc_write} = 2'b11;
        step(20);
        if_id_write = 1'b0;
        step(3);
        if_id_write = 1'b1;
        step(2);
        stop_debug = 1'b1;
        step(3);
        stop_debug = 1'b0;
        step(2);
        // Jump to word 5, then hold
        {pc_sel_jump, pc_jump} = {1'b1, 32'd5};
        step(1);
        pc_sel_jump = 1'b0;
        step(2);
        pc_write = 1'b0;
        step(3);
        pc_write = 1'b1;
        step(2);
        // Second session overwrites the low words
        load_session(12);
        {pc_sel_jump, pc_jump} = {1'b1, 32'd0};
        step(1);
        pc_sel_jump = 1'b0;
        step(14);
        $display("Run done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
fetch_pkg.sv
pc_sequencer.sv
program_loader.sv
instruction_memory.sv
fetch_stage.sv
tb_fetch_stage.sv
